// ==== design/cache_pkg.sv ====
`default_nettype none

// shared widths and types for the l1 cache and its testbench
package cache_pkg;

    // bus word geometry, fixed for both bus sides
    localparam int WORD_SIZE      = 32;             // bits per bus word
    localparam int BYTES_PER_WORD = WORD_SIZE / 8;  // byte lanes per word
    localparam int BYTE_OFF_BITS  = $clog2(BYTES_PER_WORD); // addr bits below the word

    // one bus word, used for addresses and data alike
    typedef logic [WORD_SIZE - 1:0] word_t;

    // one enable bit per byte lane, bit 0 is wdata[7:0]
    typedef logic [BYTES_PER_WORD - 1:0] byte_en_t;

    // controller states
    //   IDLE        serve hits, pass-through, start miss or flush
    //   WB          write the dirty victim line back
    //   FETCH       read the missing line, then install it
    //   FLUSH_SCAN  look at one set per cycle
    //   FLUSH_WB    write back the dirty line of the scanned set
    //   FLUSH_DONE  one cycle, pulses flush_done
    typedef enum logic [2:0] {
        IDLE,
        WB,
        FETCH,
        FLUSH_SCAN,
        FLUSH_WB,
        FLUSH_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/cache_array.sv ====
`default_nettype none

// register array, one async read port and one clocked write port
// used twice: tag entries per set, data words per set and word
module cache_array #(
    parameter int  DEPTH   = 16,                // number of entries
    parameter type entry_t = cache_pkg::word_t,  // payload stored per entry
    localparam int IDX_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic [IDX_W-1:0] rd_idx,    // read index
    output entry_t           rd_entry,  // entry at rd_idx, same cycle
    input  logic             wr_en,     // write strobe
    input  logic [IDX_W-1:0] wr_idx,    // write index
    input  entry_t           wr_entry   // written at the rising edge
);

    entry_t entries [DEPTH];

    // combinational read, no output register
    assign rd_entry = entries[rd_idx];

    // whole array cleared on reset so every tag starts invalid and clean
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_en) begin
            entries[wr_idx] <= wr_entry;  // single write per cycle
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_ctrl.sv ====
`default_nettype none

// direct mapped cache controller
// hit check, byte merge, miss handling, pass-through and flush walk
module cache_ctrl #(
    parameter int               CACHE_SIZE          = 1024, // bytes
    parameter int               BLOCK_SIZE          = 2,    // words per line
    parameter cache_pkg::word_t NONCACHE_START_ADDR = 32'h8000_0000,
    parameter type              tag_entry_t         = struct packed {
        logic        valid;
        logic        dirty;
        logic [21:0] tag;
    },
    localparam int N_SETS = CACHE_SIZE / (BLOCK_SIZE * cache_pkg::BYTES_PER_WORD),
    localparam int SET_W  = $clog2(N_SETS),
    localparam int DATA_W = $clog2(N_SETS * BLOCK_SIZE)
) (
    input  logic                CLK,
    input  logic                nRST,
    // processor side
    input  cache_pkg::word_t    proc_addr,
    input  logic                proc_ren,
    input  logic                proc_wen,
    input  cache_pkg::word_t    proc_wdata,
    input  cache_pkg::byte_en_t proc_byte_en,
    output cache_pkg::word_t    proc_rdata,
    output logic                proc_busy,
    // memory side
    output cache_pkg::word_t    mem_addr,
    output logic                mem_ren,
    output logic                mem_wen,
    output cache_pkg::word_t    mem_wdata,
    output cache_pkg::byte_en_t mem_byte_en,
    input  cache_pkg::word_t    mem_rdata,
    input  logic                mem_busy,
    // flush
    input  logic                flush,
    output logic                flush_done,
    // tag array
    output logic [SET_W-1:0]    tag_rd_idx,
    input  tag_entry_t          tag_rd_entry,
    output logic                tag_wr_en,
    output logic [SET_W-1:0]    tag_wr_idx,
    output tag_entry_t          tag_wr_entry,
    // data array, index is set and word together
    output logic [DATA_W-1:0]   data_rd_idx,
    input  cache_pkg::word_t    data_rd_word,
    output logic                data_wr_en,
    output logic [DATA_W-1:0]   data_wr_idx,
    output cache_pkg::word_t    data_wr_word
);

    localparam int N_BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int BLK_W        = (N_BLOCK_BITS > 0) ? N_BLOCK_BITS : 1;
    localparam int CNT_W        = N_BLOCK_BITS + 1;    // counts up to BLOCK_SIZE
    localparam int LINE_LSB     = N_BLOCK_BITS + cache_pkg::BYTE_OFF_BITS;
    localparam int N_TAG_BITS   = cache_pkg::WORD_SIZE - SET_W - LINE_LSB;

    cache_pkg::ctrl_state_t state, next_state;
    logic [CNT_W-1:0]       word_cnt, next_word_cnt;  // words moved in this line
    logic [SET_W-1:0]       set_cnt, next_set_cnt;    // flush walk position
    cache_pkg::word_t       bus_addr, next_bus_addr;  // memory word address

    logic [N_TAG_BITS-1:0]  proc_tag;
    logic [SET_W-1:0]       proc_set;
    logic [BLK_W-1:0]       proc_word;
    logic [SET_W-1:0]       line_set;
    logic [BLK_W-1:0]       line_word;
    logic [DATA_W-1:0]      data_idx;
    logic                   req, pass_through, hit;
    logic                   last_word, fill_done, last_set, in_flush;
    cache_pkg::word_t       merged_word;

    // byte address of word 0 of a line
    function automatic cache_pkg::word_t line_addr(input logic [N_TAG_BITS-1:0] tag,
                                                   input logic [SET_W-1:0] set);
        return {tag, set, {LINE_LSB{1'b0}}};
    endfunction

    // address decode: tag | set | word | byte
    assign proc_tag  = proc_addr[cache_pkg::WORD_SIZE-1 -: N_TAG_BITS];
    assign proc_set  = proc_addr[LINE_LSB +: SET_W];
    assign proc_word = BLK_W'((proc_addr >> cache_pkg::BYTE_OFF_BITS)
                              & cache_pkg::word_t'(BLOCK_SIZE - 1));

    assign req          = proc_ren | proc_wen;
    assign pass_through = proc_addr >= NONCACHE_START_ADDR;  // uncached window
    assign hit          = ~pass_through & tag_rd_entry.valid & (tag_rd_entry.tag == proc_tag);
    assign last_word    = word_cnt == CNT_W'(BLOCK_SIZE - 1);
    assign fill_done    = word_cnt == CNT_W'(BLOCK_SIZE);   // every word fetched
    assign last_set     = set_cnt == SET_W'(N_SETS - 1);
    assign in_flush     = (state == cache_pkg::FLUSH_SCAN) || (state == cache_pkg::FLUSH_WB);

    // flush walks set_cnt, otherwise the processor's set
    assign line_set  = in_flush ? set_cnt : proc_set;
    assign line_word = (state == cache_pkg::IDLE) ? proc_word : BLK_W'(word_cnt);
    assign data_idx  = DATA_W'(line_set * BLOCK_SIZE + line_word);

    assign tag_rd_idx  = line_set;
    assign tag_wr_idx  = line_set;
    assign data_rd_idx = data_idx;
    assign data_wr_idx = data_idx;   // same word read and written

    // write hit: enabled lanes from proc, the rest from the stored word
    always_comb begin
        merged_word = data_rd_word;
        for (int b = 0; b < cache_pkg::BYTES_PER_WORD; b++) begin
            if (proc_byte_en[b]) begin
                merged_word[8*b +: 8] = proc_wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        next_state    = state;
        next_word_cnt = word_cnt;
        next_set_cnt  = set_cnt;
        next_bus_addr = bus_addr;
        proc_busy     = 1'b1;           // busy unless a request completes
        proc_rdata    = data_rd_word;
        mem_addr      = bus_addr;
        mem_ren       = 1'b0;
        mem_wen       = 1'b0;
        mem_wdata     = data_rd_word;   // line words come straight from the array
        mem_byte_en   = '1;             // whole words on line transfers
        flush_done    = 1'b0;
        tag_wr_en     = 1'b0;
        tag_wr_entry  = tag_rd_entry;
        data_wr_en    = 1'b0;
        data_wr_word  = merged_word;

        case (state)
            cache_pkg::IDLE: begin
                if (pass_through) begin
                    // uncached, memory sees the processor request as is
                    mem_addr    = proc_addr;
                    mem_ren     = proc_ren;
                    mem_wen     = proc_wen;
                    mem_wdata   = proc_wdata;
                    mem_byte_en = proc_byte_en;
                    proc_rdata  = mem_rdata;
                    proc_busy   = req ? mem_busy : 1'b1;
                end else if (req && hit) begin
                    proc_busy = 1'b0;            // hit completes this cycle
                    if (proc_wen) begin
                        data_wr_en         = 1'b1;
                        tag_wr_en          = 1'b1;
                        tag_wr_entry.dirty = 1'b1;
                    end
                end else if (req) begin
                    next_word_cnt = '0;
                    if (tag_rd_entry.valid && tag_rd_entry.dirty) begin
                        next_state    = cache_pkg::WB;  // victim first
                        next_bus_addr = line_addr(tag_rd_entry.tag, proc_set);
                    end else begin
                        next_state    = cache_pkg::FETCH;
                        next_bus_addr = line_addr(proc_tag, proc_set);
                    end
                end
                if (flush && !req) begin
                    next_state   = cache_pkg::FLUSH_SCAN;
                    next_set_cnt = '0;
                end
            end
            cache_pkg::WB: begin
                mem_wen = 1'b1;
                if (!mem_busy) begin
                    if (last_word) begin
                        next_state    = cache_pkg::FETCH;
                        next_word_cnt = '0;
                        next_bus_addr = line_addr(proc_tag, proc_set);
                    end else begin
                        next_word_cnt = word_cnt + 1'b1;
                        next_bus_addr = bus_addr + cache_pkg::BYTES_PER_WORD;
                    end
                end
            end
            cache_pkg::FETCH: begin
                if (fill_done) begin
                    // install cycle, request then hits in IDLE
                    tag_wr_en          = 1'b1;
                    tag_wr_entry.valid = 1'b1;
                    tag_wr_entry.dirty = 1'b0;
                    tag_wr_entry.tag   = proc_tag;
                    next_word_cnt      = '0;
                    next_state         = cache_pkg::IDLE;
                end else begin
                    mem_ren = 1'b1;
                    if (!mem_busy) begin
                        data_wr_en    = 1'b1;
                        data_wr_word  = mem_rdata;
                        next_word_cnt = word_cnt + 1'b1;
                        next_bus_addr = bus_addr + cache_pkg::BYTES_PER_WORD;
                    end
                end
            end
            cache_pkg::FLUSH_SCAN: begin
                if (tag_rd_entry.valid && tag_rd_entry.dirty) begin
                    next_state    = cache_pkg::FLUSH_WB;
                    next_word_cnt = '0;
                    next_bus_addr = line_addr(tag_rd_entry.tag, set_cnt);
                end else if (last_set) begin
                    next_state = cache_pkg::FLUSH_DONE;
                end else begin
                    next_set_cnt = set_cnt + 1'b1;  // clean line, skip
                end
            end
            cache_pkg::FLUSH_WB: begin
                mem_wen = 1'b1;
                if (!mem_busy) begin
                    if (last_word) begin
                        tag_wr_en          = 1'b1;
                        tag_wr_entry.dirty = 1'b0;  // line stays valid
                        next_word_cnt      = '0;
                        if (last_set) begin
                            next_state = cache_pkg::FLUSH_DONE;
                        end else begin
                            next_set_cnt = set_cnt + 1'b1;
                            next_state   = cache_pkg::FLUSH_SCAN;
                        end
                    end else begin
                        next_word_cnt = word_cnt + 1'b1;
                        next_bus_addr = bus_addr + cache_pkg::BYTES_PER_WORD;
                    end
                end
            end
            cache_pkg::FLUSH_DONE: begin
                flush_done = 1'b1;   // single cycle pulse
                next_state = cache_pkg::IDLE;
            end
            default: next_state = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            state    <= cache_pkg::IDLE;
            word_cnt <= '0;
            set_cnt  <= '0;
            bus_addr <= '0;
        end else begin
            state    <= next_state;
            word_cnt <= next_word_cnt;
            set_cnt  <= next_set_cnt;
            bus_addr <= next_bus_addr;
        end
    end

endmodule

`default_nettype wire

// ==== design/l1_cache.sv ====
`default_nettype none

// write-back, write-allocate, direct mapped l1 cache
// tag array and data array side by side, controller on top
module l1_cache #(
    parameter int               CACHE_SIZE          = 1024,  // bytes, power of two
    parameter int               BLOCK_SIZE          = 2,     // words per line, max 8
    parameter cache_pkg::word_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                flush,
    output logic                flush_done,
    // processor side
    input  cache_pkg::word_t    proc_addr,
    input  logic                proc_ren,
    input  logic                proc_wen,
    input  cache_pkg::word_t    proc_wdata,
    input  cache_pkg::byte_en_t proc_byte_en,
    output cache_pkg::word_t    proc_rdata,
    output logic                proc_busy,
    // memory side
    output cache_pkg::word_t    mem_addr,
    output logic                mem_ren,
    output logic                mem_wen,
    output cache_pkg::word_t    mem_wdata,
    output cache_pkg::byte_en_t mem_byte_en,
    input  cache_pkg::word_t    mem_rdata,
    input  logic                mem_busy
);

    // geometry
    localparam int N_SETS       = CACHE_SIZE / (BLOCK_SIZE * cache_pkg::BYTES_PER_WORD);
    localparam int N_SET_BITS   = $clog2(N_SETS);
    localparam int N_BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int N_TAG_BITS   = cache_pkg::WORD_SIZE - N_SET_BITS - N_BLOCK_BITS
                                  - cache_pkg::BYTE_OFF_BITS;
    localparam int N_WORDS      = N_SETS * BLOCK_SIZE;   // data array depth
    localparam int DATA_W       = $clog2(N_WORDS);

    // one tag entry per set
    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [N_TAG_BITS-1:0] tag;
    } tag_entry_t;

    logic [N_SET_BITS-1:0] tag_rd_idx, tag_wr_idx;
    tag_entry_t            tag_rd_entry, tag_wr_entry;
    logic                  tag_wr_en;
    logic [DATA_W-1:0]     data_rd_idx, data_wr_idx;
    cache_pkg::word_t      data_rd_word, data_wr_word;
    logic                  data_wr_en;

    cache_array #(
        .DEPTH   (N_SETS),
        .entry_t (tag_entry_t)
    ) i_tag_array (
        .CLK      (CLK),
        .nRST     (nRST),
        .rd_idx   (tag_rd_idx),
        .rd_entry (tag_rd_entry),
        .wr_en    (tag_wr_en),
        .wr_idx   (tag_wr_idx),
        .wr_entry (tag_wr_entry)
    );

    // data words, indexed by set and word within the line
    cache_array #(
        .DEPTH   (N_WORDS),
        .entry_t (cache_pkg::word_t)
    ) i_data_array (
        .CLK      (CLK),
        .nRST     (nRST),
        .rd_idx   (data_rd_idx),
        .rd_entry (data_rd_word),
        .wr_en    (data_wr_en),
        .wr_idx   (data_wr_idx),
        .wr_entry (data_wr_word)
    );

    cache_ctrl #(
        .CACHE_SIZE          (CACHE_SIZE),
        .BLOCK_SIZE          (BLOCK_SIZE),
        .NONCACHE_START_ADDR (NONCACHE_START_ADDR),
        .tag_entry_t         (tag_entry_t)
    ) i_cache_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .proc_addr    (proc_addr),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .mem_addr     (mem_addr),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy),
        .flush        (flush),
        .flush_done   (flush_done),
        .tag_rd_idx   (tag_rd_idx),
        .tag_rd_entry (tag_rd_entry),
        .tag_wr_en    (tag_wr_en),
        .tag_wr_idx   (tag_wr_idx),
        .tag_wr_entry (tag_wr_entry),
        .data_rd_idx  (data_rd_idx),
        .data_rd_word (data_rd_word),
        .data_wr_en   (data_wr_en),
        .data_wr_idx  (data_wr_idx),
        .data_wr_word (data_wr_word)
    );

endmodule

`default_nettype wire

// ==== testbench/l1_cache_props.sv ====
`default_nettype none

// bus protocol properties, bound into every l1_cache
module l1_cache_props #(
    parameter cache_pkg::word_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input logic             CLK,
    input logic             nRST,
    input logic             flush,
    input logic             flush_done,
    input cache_pkg::word_t proc_addr,
    input logic             proc_ren,
    input logic             proc_wen,
    input cache_pkg::word_t mem_addr,
    input logic             mem_ren,
    input logic             mem_wen,
    input logic             mem_busy
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned error_count = 0;  // failed assertions so far
    logic        flush_open;       // flush taken, done pulse still owed

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            flush_open <= 1'b0;
        end else if (flush_done) begin
            flush_open <= 1'b0;
        end else if (flush && !proc_ren && !proc_wen) begin
            flush_open <= 1'b1;  // a processor request would block it
        end
    end

    no_rd_wr_overlap: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else begin
            error_count++;
            $error("mem_ren and mem_wen are high in the same cycle");
        end

    // first cycle out of reset, bus idle
    quiet_after_reset: assert property (@(posedge CLK)
        $rose(nRST) |-> !mem_ren && !mem_wen && !flush_done)
        else begin
            error_count++;
            $error("memory bus or flush_done active right after reset");
        end

    done_single_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else begin
            error_count++;
            $error("flush_done is longer than one cycle");
        end

    done_needs_flush: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |-> flush_open)
        else begin
            error_count++;
            $error("flush_done without an accepted flush");
        end

    uncached_addr: assert property (@(posedge CLK) disable iff (!nRST)
        (proc_ren || proc_wen) && (proc_addr >= NONCACHE_START_ADDR)
        |-> mem_addr == proc_addr)
        else begin
            error_count++;
            $error("mem_addr differs from proc_addr on an uncached request");
        end

    // back-pressure holds the word address
    stall_holds_addr: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_busy |=> $stable(mem_addr))
        else begin
            error_count++;
            $error("mem_addr moved while mem_busy was high");
        end

endmodule

bind l1_cache l1_cache_props #(
    .NONCACHE_START_ADDR (NONCACHE_START_ADDR)
) i_l1_cache_props (
    .CLK        (CLK),
    .nRST       (nRST),
    .flush      (flush),
    .flush_done (flush_done),
    .proc_addr  (proc_addr),
    .proc_ren   (proc_ren),
    .proc_wen   (proc_wen),
    .mem_addr   (mem_addr),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .mem_busy   (mem_busy)
);

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`default_nettype none

// clock and power-on reset for the testbench
module tb_clock (
    output logic CLK,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20;  // 40 ns period
    localparam int RESET_CYCLES = 8;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;  // released on a rising edge
    end

endmodule

`default_nettype wire

// ==== testbench/tb_l1_cache.sv ====
`default_nettype none

// random cached and uncached traffic with flushes, checked against a shadow memory
module tb_l1_cache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int               BLOCK_SIZE  = 2;    // DUT default
    localparam int               N_SETS      = 128;  // 1024 bytes in 2-word lines
    localparam int               N_OPS       = 200;
    localparam int               FLUSH_EVERY = 25;
    localparam int               MEM_WORDS   = 2048;
    localparam logic [31:0]      SEED        = 32'hb31f8d6f;
    localparam cache_pkg::word_t UNCACHED    = 32'h8000_0000;
    // every op may add a read-back, flushes scan all sets
    localparam int TIMEOUT_CYCLES = 2 * N_OPS * 4 * BLOCK_SIZE * 3
                                    + (N_OPS / FLUSH_EVERY + 1) * 3 * N_SETS + 100;

    typedef logic [10:0] mem_idx_t;  // addr[31] and addr[11:2]

    logic                CLK, nRST;
    logic                flush, flush_done;
    cache_pkg::word_t    proc_addr, proc_wdata, proc_rdata;
    logic                proc_ren, proc_wen, proc_busy;
    cache_pkg::byte_en_t proc_byte_en, mem_byte_en;
    cache_pkg::word_t    mem_addr, mem_wdata, mem_rdata;
    logic                mem_ren, mem_wen, mem_busy;

    cache_pkg::word_t backing [MEM_WORDS];  // memory behind the cache
    cache_pkg::word_t shadow  [MEM_WORDS];  // processor's expected view
    logic             written [MEM_WORDS];  // cached words written so far
    integer           stim_seed, mem_seed;

    function automatic mem_idx_t mem_index(input cache_pkg::word_t addr);
        return {addr[31], addr[11:2]};
    endfunction

    function automatic cache_pkg::word_t addr_of(input mem_idx_t idx);
        return {idx[10], 19'b0, idx[9:0], 2'b00};
    endfunction

    function automatic cache_pkg::word_t fill_word(input cache_pkg::word_t addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h6b2d_91e3;
    endfunction

    // enabled byte lanes from new_word, the rest kept
    function automatic cache_pkg::word_t merge_lanes(input cache_pkg::word_t old_word,
                                                     input cache_pkg::word_t new_word,
                                                     input cache_pkg::byte_en_t be);
        cache_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    tb_clock i_tb_clock (
        .CLK  (CLK),
        .nRST (nRST)
    );

    l1_cache i_l1_cache (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .flush_done   (flush_done),
        .proc_addr    (proc_addr),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .mem_addr     (mem_addr),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy)
    );

    assign mem_rdata = backing[mem_index(mem_addr)];  // read data always valid

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    // memory model, 0 to 2 busy cycles before every word
    initial begin
        logic                seen_req, seen_busy, seen_wr;
        mem_idx_t            seen_idx;
        cache_pkg::word_t    seen_data;
        cache_pkg::byte_en_t seen_be;
        logic [1:0]          busy_cnt, delay;
        mem_seed = SEED;
        busy_cnt = 2'd0;
        mem_busy <= 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            backing[i] <= fill_word(addr_of(mem_idx_t'(i)));
        end
        forever begin
            @(negedge CLK);                  // bus stable mid-cycle
            seen_req  = nRST && (mem_ren || mem_wen);
            seen_busy = mem_busy;
            seen_wr   = mem_wen;
            seen_idx  = mem_index(mem_addr);
            seen_data = mem_wdata;
            seen_be   = mem_byte_en;
            @(posedge CLK);
            if (seen_req && !seen_busy) begin  // word done at this edge
                if (seen_wr) begin
                    backing[seen_idx] <= merge_lanes(backing[seen_idx], seen_data, seen_be);
                end
                delay    = 2'({$random(mem_seed)} % 3);
                busy_cnt = delay;
                mem_busy <= delay != 2'd0;
            end else if (seen_req) begin
                busy_cnt = busy_cnt - 2'd1;
                mem_busy <= busy_cnt != 2'd0;
            end
        end
    end

    // cached: 4 tags over 4 sets so lines collide, uncached: 8 words
    task automatic pick_addr(output cache_pkg::word_t addr);
        int unsigned kind, tag, set, word;
        kind = {$random(stim_seed)} % 8;
        tag  = {$random(stim_seed)} % 4;
        set  = {$random(stim_seed)} % 4;
        word = {$random(stim_seed)} % 8;
        if (kind < 6) begin
            addr = cache_pkg::word_t'((tag << 10) | (set << 3) | ((word % 2) << 2));
        end else begin
            addr = UNCACHED | cache_pkg::word_t'(word << 2);
        end
    endtask

    // one processor request, held until proc_busy drops
    task automatic run_access(input logic wr, input cache_pkg::word_t addr,
                              input cache_pkg::word_t data, input cache_pkg::byte_en_t be);
        mem_idx_t idx;
        idx = mem_index(addr);
        @(posedge CLK);
        proc_addr    <= addr;
        proc_ren     <= !wr;
        proc_wen     <= wr;
        proc_wdata   <= data;
        proc_byte_en <= be;
        @(negedge CLK);
        while (proc_busy) @(negedge CLK);
        if (wr) begin  // completes at the next edge
            shadow[idx] = merge_lanes(shadow[idx], data, be);
            written[idx] = written[idx] | (addr < UNCACHED);
        end else begin
            assert (proc_rdata == shadow[idx]) else begin
                $display("Mismatch proc_rdata at %h: got %h, expected %h",
                         addr, proc_rdata, shadow[idx]);
                abort_run();
            end
        end
    endtask

    task automatic check_backing();
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (written[i]) begin
                assert (backing[i] == shadow[i]) else begin
                    $display("Mismatch backing at %h after flush: got %h, expected %h",
                             addr_of(mem_idx_t'(i)), backing[i], shadow[i]);
                    abort_run();
                end
            end
        end
    endtask

    task automatic flush_cache();
        @(posedge CLK);
        proc_ren <= 1'b0;
        proc_wen <= 1'b0;
        flush    <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;   // one cycle pulse
        @(negedge CLK);
        while (!flush_done) @(negedge CLK);
        check_backing();
    endtask

    // bound assertions count their failures
    always @(negedge CLK) begin
        if (i_l1_cache.i_l1_cache_props.error_count != 0) begin
            $display("a bus protocol assertion failed");
            abort_run();
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 40);
        $display("timeout: no progress within %0d cycles", TIMEOUT_CYCLES);
        abort_run();
    end

    initial begin
        cache_pkg::word_t    addr, data;
        cache_pkg::byte_en_t be;
        logic                wr;
        stim_seed = SEED;
        flush        <= 1'b0;
        proc_addr    <= '0;
        proc_ren     <= 1'b0;
        proc_wen     <= 1'b0;
        proc_wdata   <= '0;
        proc_byte_en <= '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i]  = fill_word(addr_of(mem_idx_t'(i)));
            written[i] = 1'b0;
        end
        @(posedge nRST);
        for (int n = 0; n < N_OPS; n++) begin
            pick_addr(addr);
            wr   = 1'($random(stim_seed));
            data = $random(stim_seed);
            be   = wr ? 4'($random(stim_seed)) : 4'hf;
            run_access(wr, addr, data, be);
            if (wr && be != 4'hf) begin
                run_access(1'b0, addr, '0, 4'hf);  // partial write, read back
            end
            if (n % FLUSH_EVERY == FLUSH_EVERY - 1) begin
                flush_cache();
            end
        end
        flush_cache();
        if (i_l1_cache.i_l1_cache_props.error_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("a bus protocol assertion failed in the last cycle");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/cache_pkg.sv
design/cache_array.sv
design/cache_ctrl.sv
design/l1_cache.sv
testbench/l1_cache_props.sv
testbench/tb_clock.sv
testbench/tb_l1_cache.sv

// ==== Makefile ====
TOP := tb_l1_cache
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f all.f -Mdir obj_dir -o $(TOP)

run: compile
	-./obj_dir/$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
